// File: Bender.yml
package:
  name: vga_scene

sources:
  - hdl/vga_timing_pkg.sv
  - hdl/scene_pkg.sv
  - hdl/vga_counters.sv
  - hdl/score_regs.sv
  - hdl/backdrop_painter.sv
  - hdl/score_overlay.sv
  - hdl/vga_scene.sv
  - target: test
    files:
      - verification/vga_scene_tb.sv

// File: filelist.f
hdl/vga_timing_pkg.sv
hdl/scene_pkg.sv
hdl/vga_counters.sv
hdl/score_regs.sv
hdl/backdrop_painter.sv
hdl/score_overlay.sv
hdl/vga_scene.sv
verification/vga_scene_tb.sv

// File: hdl/backdrop_painter.sv
`default_nettype none
`timescale 1ns/1ns

module backdrop_painter #(
    parameter int night_delay = 10_000_000
) (
    input  logic                                clk,
    input  logic                                reset,
    input  logic [vga_timing_pkg::HCOUNT_W-1:0] hcount,
    input  logic [vga_timing_pkg::VCOUNT_W-1:0] vcount,
    output logic [scene_pkg::COLOR_W-1:0]       bg_r,
    output logic [scene_pkg::COLOR_W-1:0]       bg_g,
    output logic [scene_pkg::COLOR_W-1:0]       bg_b
);
    import vga_timing_pkg::*;
    import scene_pkg::*;

    localparam int TIMER_W = $clog2(night_delay + 1);

    logic [TIMER_W-1:0]        night_timer;
    logic                      night;
    logic signed [HCOUNT_W:0]  dx;
    logic signed [VCOUNT_W:0]  dy;
    logic [2*HCOUNT_W+2:0]     dist2;

    // Counts up once after reset, then stops with night set
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            night_timer <= '0;
            night       <= 1'b0;
        end else if (!night) begin
            if (night_timer == TIMER_W'(night_delay - 1)) begin
                night <= 1'b1;
            end else begin
                night_timer <= night_timer + 1'b1;
            end
        end
    end

    // Squared distance from the sun centre
    always_comb begin
        dx    = $signed({1'b0, hcount}) - $signed((HCOUNT_W + 1)'(SUN_CX));
        dy    = $signed({1'b0, vcount}) - $signed((VCOUNT_W + 1)'(SUN_CY));
        dist2 = dx * dx + dy * dy;
    end

    always_comb begin
        if (vcount < VCOUNT_W'(GROUND_LINE_V)) begin
            bg_r = night ? SKY_NIGHT_R : SKY_DAY_R;
            bg_g = night ? SKY_NIGHT_G : SKY_DAY_G;
            bg_b = night ? SKY_NIGHT_B : SKY_DAY_B;
        end else if (vcount == VCOUNT_W'(GROUND_LINE_V)) begin
            bg_r = '0;
            bg_g = '0;
            bg_b = '0;
        end else if (vcount < VCOUNT_W'(GROUND_SPLIT_V)) begin
            bg_r = GROUND_LIGHT_R;
            bg_g = GROUND_LIGHT_G;
            bg_b = GROUND_LIGHT_B;
        end else begin
            bg_r = GROUND_DARK_R;
            bg_g = GROUND_DARK_G;
            bg_b = GROUND_DARK_B;
        end

        // Sun goes on top of whatever band is under it
        if (dist2 < SUN_CORE_R2) begin
            bg_r = SUN_CORE_R;
            bg_g = SUN_CORE_G;
            bg_b = SUN_CORE_B;
        end else if (dist2 < SUN_GLOW_R2) begin
            bg_r = SUN_GLOW_R;
            bg_g = SUN_GLOW_G;
            bg_b = SUN_GLOW_B;
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        night |=> night)
        else $error("backdrop_painter: night cleared without reset");

endmodule

`default_nettype wire

// File: hdl/scene_pkg.sv
`default_nettype none

package scene_pkg;

    localparam int COLOR_W = 8;

    // Bus and register field widths
    localparam int ADDR_W  = 9;
    localparam int DATA_W  = 32;
    localparam int SCORE_W = 4;
    localparam int POS_W   = 8;

    // Sky by day and by night
    localparam logic [COLOR_W-1:0] SKY_DAY_R   = COLOR_W'(135);
    localparam logic [COLOR_W-1:0] SKY_DAY_G   = COLOR_W'(206);
    localparam logic [COLOR_W-1:0] SKY_DAY_B   = COLOR_W'(235);
    localparam logic [COLOR_W-1:0] SKY_NIGHT_R = COLOR_W'(10);
    localparam logic [COLOR_W-1:0] SKY_NIGHT_G = COLOR_W'(10);
    localparam logic [COLOR_W-1:0] SKY_NIGHT_B = COLOR_W'(40);

    // Black line at GROUND_LINE_V, light band down to GROUND_SPLIT_V
    localparam int GROUND_LINE_V  = 280;
    localparam int GROUND_SPLIT_V = 300;

    localparam logic [COLOR_W-1:0] GROUND_LIGHT_R = COLOR_W'(139);
    localparam logic [COLOR_W-1:0] GROUND_LIGHT_G = COLOR_W'(69);
    localparam logic [COLOR_W-1:0] GROUND_LIGHT_B = COLOR_W'(19);
    localparam logic [COLOR_W-1:0] GROUND_DARK_R  = COLOR_W'(100);
    localparam logic [COLOR_W-1:0] GROUND_DARK_G  = COLOR_W'(40);
    localparam logic [COLOR_W-1:0] GROUND_DARK_B  = COLOR_W'(10);

    // Sun centre and squared radii
    localparam int SUN_CX      = 1150;
    localparam int SUN_CY      = 80;
    localparam int SUN_CORE_R2 = 900;
    localparam int SUN_GLOW_R2 = 1200;

    localparam logic [COLOR_W-1:0] SUN_CORE_R = COLOR_W'(255);
    localparam logic [COLOR_W-1:0] SUN_CORE_G = COLOR_W'(255);
    localparam logic [COLOR_W-1:0] SUN_CORE_B = COLOR_W'(0);
    localparam logic [COLOR_W-1:0] SUN_GLOW_R = COLOR_W'(255);
    localparam logic [COLOR_W-1:0] SUN_GLOW_G = COLOR_W'(255);
    localparam logic [COLOR_W-1:0] SUN_GLOW_B = COLOR_W'(100);

    // Register map
    localparam logic [ADDR_W-1:0] REG_SCORE   = ADDR_W'(10);
    localparam logic [ADDR_W-1:0] REG_SCORE_X = ADDR_W'(11);
    localparam logic [ADDR_W-1:0] REG_SCORE_Y = ADDR_W'(12);

    localparam logic [POS_W-1:0] SCORE_RESET_X = POS_W'(25);
    localparam logic [POS_W-1:0] SCORE_RESET_Y = POS_W'(41);

    // Digit sits this far right of score_x
    localparam int DIGIT_OFFSET_X = 20;
    localparam int GLYPH_SIZE     = 8;

endpackage

`default_nettype wire

// File: hdl/score_overlay.sv
`default_nettype none
`timescale 1ns/1ns

module score_overlay (
    input  logic [vga_timing_pkg::HCOUNT_W-1:0] hcount,
    input  logic [vga_timing_pkg::VCOUNT_W-1:0] vcount,
    input  logic [scene_pkg::SCORE_W-1:0]       score,
    input  logic [scene_pkg::POS_W-1:0]         score_x,
    input  logic [scene_pkg::POS_W-1:0]         score_y,
    input  logic [scene_pkg::COLOR_W-1:0]       bg_r,
    input  logic [scene_pkg::COLOR_W-1:0]       bg_g,
    input  logic [scene_pkg::COLOR_W-1:0]       bg_b,
    output logic [scene_pkg::COLOR_W-1:0]       pix_r,
    output logic [scene_pkg::COLOR_W-1:0]       pix_g,
    output logic [scene_pkg::COLOR_W-1:0]       pix_b
);
    import vga_timing_pkg::*;
    import scene_pkg::*;

    // Digits 0..9, top row first, bit 7 is the leftmost pixel
    localparam logic [GLYPH_SIZE-1:0] FONT [0:9][0:GLYPH_SIZE-1] = '{
        '{8'h3C, 8'h66, 8'h6E, 8'h7E, 8'h76, 8'h66, 8'h3C, 8'h00},
        '{8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h18, 8'h7E, 8'h00},
        '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h30, 8'h66, 8'h7E, 8'h00},
        '{8'h3C, 8'h66, 8'h06, 8'h1C, 8'h06, 8'h66, 8'h3C, 8'h00},
        '{8'h0C, 8'h1C, 8'h2C, 8'h4C, 8'h7E, 8'h0C, 8'h0C, 8'h00},
        '{8'h7E, 8'h60, 8'h7C, 8'h06, 8'h06, 8'h66, 8'h3C, 8'h00},
        '{8'h3C, 8'h66, 8'h60, 8'h7C, 8'h66, 8'h66, 8'h3C, 8'h00},
        '{8'h7E, 8'h06, 8'h0C, 8'h18, 8'h30, 8'h30, 8'h30, 8'h00},
        '{8'h3C, 8'h66, 8'h66, 8'h3C, 8'h66, 8'h66, 8'h3C, 8'h00},
        '{8'h3C, 8'h66, 8'h66, 8'h3E, 8'h06, 8'h66, 8'h3C, 8'h00}
    };

    logic [HCOUNT_W-1:0]            digit_left;
    logic [HCOUNT_W-1:0]            col_off;
    logic [VCOUNT_W-1:0]            row_off;
    logic [$clog2(GLYPH_SIZE)-1:0]  col_idx;
    logic [$clog2(GLYPH_SIZE)-1:0]  bit_idx;
    logic [GLYPH_SIZE-1:0]          glyph_bits;
    logic                           in_box;
    logic                           hit;

    assign digit_left = HCOUNT_W'(score_x) + HCOUNT_W'(DIGIT_OFFSET_X);

    // Left of or above the box wraps to a large offset
    assign col_off = hcount - digit_left;
    assign row_off = vcount - VCOUNT_W'(score_y);
    assign in_box  = (col_off < HCOUNT_W'(GLYPH_SIZE)) && (row_off < VCOUNT_W'(GLYPH_SIZE));

    assign col_idx = col_off[$clog2(GLYPH_SIZE)-1:0];
    // 7 - column
    assign bit_idx = ~col_idx;

    assign glyph_bits = (score <= SCORE_W'(9)) ?
                        FONT[score][row_off[$clog2(GLYPH_SIZE)-1:0]] : '0;

    assign hit = in_box && glyph_bits[bit_idx];

    always_comb begin
        if (hit) begin
            pix_r = '0;
            pix_g = '0;
            pix_b = '0;
        end else begin
            pix_r = bg_r;
            pix_g = bg_g;
            pix_b = bg_b;
        end
    end

endmodule

`default_nettype wire

// File: hdl/score_regs.sv
`default_nettype none
`timescale 1ns/1ns

module score_regs (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          chipselect,
    input  logic                          write,
    input  logic [scene_pkg::ADDR_W-1:0]  address,
    input  logic [scene_pkg::DATA_W-1:0]  writedata,
    output logic [scene_pkg::SCORE_W-1:0] score,
    output logic [scene_pkg::POS_W-1:0]   score_x,
    output logic [scene_pkg::POS_W-1:0]   score_y
);
    import scene_pkg::*;

    logic wr_en;

    // Single-cycle strobe, always accepted
    assign wr_en = chipselect && write;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            score   <= '0;
            score_x <= SCORE_RESET_X;
            score_y <= SCORE_RESET_Y;
        end else if (wr_en) begin
            case (address)
                REG_SCORE: begin
                    score <= writedata[SCORE_W-1:0];
                end
                REG_SCORE_X: begin
                    score_x <= writedata[POS_W-1:0];
                end
                REG_SCORE_Y: begin
                    score_y <= writedata[POS_W-1:0];
                end
                default: begin
                    // unmapped addresses are dropped
                end
            endcase
        end
    end

    assert property (@(posedge clk) disable iff (reset)
        wr_en |-> !$isunknown({address, writedata}))
        else $error("score_regs: unknown address or data during a write");

endmodule

`default_nettype wire

// File: hdl/vga_counters.sv
`default_nettype none
`timescale 1ns/1ns

module vga_counters (
    input  logic                                clk,
    input  logic                                reset,
    output logic [vga_timing_pkg::HCOUNT_W-1:0] hcount,
    output logic [vga_timing_pkg::VCOUNT_W-1:0] vcount,
    output logic                                hsync,
    output logic                                vsync,
    output logic                                blank_n,
    output logic                                pix_clk
);
    import vga_timing_pkg::*;

    logic end_of_line;
    logic end_of_frame;

    assign end_of_line  = (hcount == HCOUNT_W'(H_TOTAL - 1));
    assign end_of_frame = (vcount == VCOUNT_W'(V_TOTAL - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            hcount <= '0;
        end else if (end_of_line) begin
            hcount <= '0;
        end else begin
            hcount <= hcount + 1'b1;
        end
    end

    // Lines advance only on the last count of a line
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            vcount <= '0;
        end else if (end_of_line) begin
            if (end_of_frame) begin
                vcount <= '0;
            end else begin
                vcount <= vcount + 1'b1;
            end
        end
    end

    // Both syncs are active low
    assign hsync = !((hcount >= HCOUNT_W'(H_ACTIVE + H_FRONT)) &&
                     (hcount < HCOUNT_W'(H_ACTIVE + H_FRONT + H_SYNC)));
    assign vsync = !((vcount >= VCOUNT_W'(V_ACTIVE + V_FRONT)) &&
                     (vcount < VCOUNT_W'(V_ACTIVE + V_FRONT + V_SYNC)));

    assign blank_n = (hcount < HCOUNT_W'(H_ACTIVE)) && (vcount < VCOUNT_W'(V_ACTIVE));
    assign pix_clk = hcount[0];

    assert property (@(posedge clk) disable iff (reset)
        (hcount < HCOUNT_W'(H_TOTAL)) && (vcount < VCOUNT_W'(V_TOTAL)))
        else $error("vga_counters: raster counter out of range");

endmodule

`default_nettype wire

// File: hdl/vga_scene.sv
`default_nettype none
`timescale 1ns/1ns

module vga_scene #(
    parameter int night_delay = 10_000_000
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic [scene_pkg::DATA_W-1:0]  writedata,
    input  logic                          write,
    input  logic                          chipselect,
    input  logic [scene_pkg::ADDR_W-1:0]  address,
    output logic [scene_pkg::COLOR_W-1:0] VGA_R,
    output logic [scene_pkg::COLOR_W-1:0] VGA_G,
    output logic [scene_pkg::COLOR_W-1:0] VGA_B,
    output logic                          VGA_CLK,
    output logic                          VGA_HS,
    output logic                          VGA_VS,
    output logic                          VGA_BLANK_n,
    output logic                          VGA_SYNC_n
);
    import vga_timing_pkg::*;
    import scene_pkg::*;

    logic [HCOUNT_W-1:0] hcount;
    logic [VCOUNT_W-1:0] vcount;
    logic                blank_n;
    logic [SCORE_W-1:0]  score;
    logic [POS_W-1:0]    score_x;
    logic [POS_W-1:0]    score_y;
    logic [COLOR_W-1:0]  bg_r;
    logic [COLOR_W-1:0]  bg_g;
    logic [COLOR_W-1:0]  bg_b;
    logic [COLOR_W-1:0]  pix_r;
    logic [COLOR_W-1:0]  pix_g;
    logic [COLOR_W-1:0]  pix_b;

    vga_counters counters0 (
        .clk     (clk),
        .reset   (reset),
        .hcount  (hcount),
        .vcount  (vcount),
        .hsync   (VGA_HS),
        .vsync   (VGA_VS),
        .blank_n (blank_n),
        .pix_clk (VGA_CLK)
    );

    score_regs regs0 (
        .clk        (clk),
        .reset      (reset),
        .chipselect (chipselect),
        .write      (write),
        .address    (address),
        .writedata  (writedata),
        .score      (score),
        .score_x    (score_x),
        .score_y    (score_y)
    );

    backdrop_painter #(
        .night_delay (night_delay)
    ) backdrop0 (
        .clk    (clk),
        .reset  (reset),
        .hcount (hcount),
        .vcount (vcount),
        .bg_r   (bg_r),
        .bg_g   (bg_g),
        .bg_b   (bg_b)
    );

    score_overlay overlay0 (
        .hcount  (hcount),
        .vcount  (vcount),
        .score   (score),
        .score_x (score_x),
        .score_y (score_y),
        .bg_r    (bg_r),
        .bg_g    (bg_g),
        .bg_b    (bg_b),
        .pix_r   (pix_r),
        .pix_g   (pix_g),
        .pix_b   (pix_b)
    );

    // One cycle behind the counters, black outside the active area
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            VGA_R <= '0;
            VGA_G <= '0;
            VGA_B <= '0;
        end else if (blank_n) begin
            VGA_R <= pix_r;
            VGA_G <= pix_g;
            VGA_B <= pix_b;
        end else begin
            VGA_R <= '0;
            VGA_G <= '0;
            VGA_B <= '0;
        end
    end

    assign VGA_BLANK_n = blank_n;
    assign VGA_SYNC_n  = 1'b0;

endmodule

`default_nettype wire

// File: hdl/vga_timing_pkg.sv
`default_nettype none

package vga_timing_pkg;

    // Horizontal raster, in pixel-clock counts
    localparam int H_ACTIVE = 1280;
    localparam int H_FRONT  = 32;
    localparam int H_SYNC   = 192;
    localparam int H_BACK   = 96;
    localparam int H_TOTAL  = 1600;

    // Vertical raster, in lines
    localparam int V_ACTIVE = 480;
    localparam int V_FRONT  = 10;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 33;
    localparam int V_TOTAL  = 525;

    // Wide enough for H_TOTAL - 1 and V_TOTAL - 1
    localparam int HCOUNT_W = 11;
    localparam int VCOUNT_W = 10;

endpackage

`default_nettype wire

// File: verification/vga_scene_tb.sv
`default_nettype none
`timescale 1ns/1ns

module vga_scene_tb;
    import vga_timing_pkg::*;
    import scene_pkg::*;

    localparam int NIGHT_DELAY = 1_000_000;
    localparam int WAIT_LIMIT  = H_TOTAL * V_TOTAL + 1000;
    localparam int VBLANK_LINE = V_ACTIVE + V_FRONT;

    logic               clk;
    logic               reset;
    logic [DATA_W-1:0]  writedata;
    logic               write;
    logic               chipselect;
    logic [ADDR_W-1:0]  address;
    logic [COLOR_W-1:0] vga_r;
    logic [COLOR_W-1:0] vga_g;
    logic [COLOR_W-1:0] vga_b;
    logic               vga_clk;
    logic               vga_hs;
    logic               vga_vs;
    logic               vga_blank_n;
    logic               vga_sync_n;

    integer seed;
    int     digit;
    int     pos_x;
    int     pos_y;

    // Raster and register model
    int                   model_h;
    int                   model_v;
    int                   cycles;
    logic                 model_night;
    logic [SCORE_W-1:0]   model_score;
    logic [POS_W-1:0]     model_x;
    logic [POS_W-1:0]     model_y;
    logic                 exp_hs;
    logic                 exp_vs;
    logic                 exp_blank_n;
    logic                 exp_active;
    logic [3*COLOR_W-1:0] exp_rgb;
    logic [COLOR_W-1:0]   exp_r;
    logic [COLOR_W-1:0]   exp_g;
    logic [COLOR_W-1:0]   exp_b;

    vga_scene #(
        .night_delay (NIGHT_DELAY)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .writedata   (writedata),
        .write       (write),
        .chipselect  (chipselect),
        .address     (address),
        .VGA_R       (vga_r),
        .VGA_G       (vga_g),
        .VGA_B       (vga_b),
        .VGA_CLK     (vga_clk),
        .VGA_HS      (vga_hs),
        .VGA_VS      (vga_vs),
        .VGA_BLANK_n (vga_blank_n),
        .VGA_SYNC_n  (vga_sync_n)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Digit font, top row in the high byte
    function automatic logic [63:0] glyph(input int d);
        case (d)
            0: return 64'h3C666E7E76663C00;
            1: return 64'h183818181818_7E00;
            2: return 64'h3C66061C30667E00;
            3: return 64'h3C66061C06663C00;
            4: return 64'h0C1C2C4C7E0C0C00;
            5: return 64'h7E607C0606663C00;
            6: return 64'h3C66607C66663C00;
            7: return 64'h7E060C1830303000;
            8: return 64'h3C66663C66663C00;
            default: return 64'h3C66663E06663C00;
        endcase
    endfunction

    function automatic logic [3*COLOR_W-1:0] scene_colour(input int h, input int v,
            input logic night_on, input int score, input int sx, input int sy);
        logic [3*COLOR_W-1:0] c;
        logic [63:0]          g;
        int                   d2;
        int                   col;
        if (v < GROUND_LINE_V) begin
            c = night_on ? {SKY_NIGHT_R, SKY_NIGHT_G, SKY_NIGHT_B} :
                           {SKY_DAY_R, SKY_DAY_G, SKY_DAY_B};
        end else if (v == GROUND_LINE_V) begin
            c = '0;
        end else if (v < GROUND_SPLIT_V) begin
            c = {GROUND_LIGHT_R, GROUND_LIGHT_G, GROUND_LIGHT_B};
        end else begin
            c = {GROUND_DARK_R, GROUND_DARK_G, GROUND_DARK_B};
        end
        d2 = (h - SUN_CX) * (h - SUN_CX) + (v - SUN_CY) * (v - SUN_CY);
        if (d2 < SUN_CORE_R2) begin
            c = {SUN_CORE_R, SUN_CORE_G, SUN_CORE_B};
        end else if (d2 < SUN_GLOW_R2) begin
            c = {SUN_GLOW_R, SUN_GLOW_G, SUN_GLOW_B};
        end
        col = h - sx - DIGIT_OFFSET_X;
        if (col >= 0 && col < GLYPH_SIZE && v >= sy && v < sy + GLYPH_SIZE && score <= 9) begin
            g = glyph(score);
            // Row byte, then column 0 at its top bit
            if (g[63 - 8 * (v - sy) - col]) begin
                c = '0;
            end
        end
        return c;
    endfunction

    assign model_night = (cycles >= NIGHT_DELAY);
    assign exp_hs      = !((model_h >= H_ACTIVE + H_FRONT) &&
                           (model_h < H_ACTIVE + H_FRONT + H_SYNC));
    assign exp_vs      = !((model_v >= V_ACTIVE + V_FRONT) &&
                           (model_v < V_ACTIVE + V_FRONT + V_SYNC));
    assign exp_blank_n = (model_h < H_ACTIVE) && (model_v < V_ACTIVE);
    assign exp_r       = exp_rgb[3*COLOR_W-1:2*COLOR_W];
    assign exp_g       = exp_rgb[2*COLOR_W-1:COLOR_W];
    assign exp_b       = exp_rgb[COLOR_W-1:0];

    always @(posedge clk or posedge reset) begin
        if (reset) begin
            model_h     <= 0;
            model_v     <= 0;
            cycles      <= 0;
            model_score <= '0;
            model_x     <= SCORE_RESET_X;
            model_y     <= SCORE_RESET_Y;
            exp_rgb     <= '0;
            exp_active  <= 1'b0;
        end else begin
            // Pixel for the counters of this cycle shows up next cycle
            exp_active <= exp_blank_n;
            exp_rgb    <= exp_blank_n ? scene_colour(model_h, model_v, model_night,
                                                     model_score, model_x, model_y) : '0;
            if (model_h == H_TOTAL - 1) begin
                model_h <= 0;
                model_v <= (model_v == V_TOTAL - 1) ? 0 : model_v + 1;
            end else begin
                model_h <= model_h + 1;
            end
            cycles <= cycles + 1;
            if (chipselect && write) begin
                if (address == REG_SCORE) model_score <= writedata[SCORE_W-1:0];
                if (address == REG_SCORE_X) model_x <= writedata[POS_W-1:0];
                if (address == REG_SCORE_Y) model_y <= writedata[POS_W-1:0];
            end
        end
    end

    task automatic stop_run();
        $display("Simulation failed");
        $fatal(1, "stopped at first error");
    endtask

    assert property (@(posedge clk) disable iff (reset) vga_hs == exp_hs)
        else begin
            $display("mismatch at %0t: VGA_HS expected %b, got %b",
                     $time, $sampled(exp_hs), $sampled(vga_hs));
            stop_run();
        end

    assert property (@(posedge clk) disable iff (reset) vga_vs == exp_vs)
        else begin
            $display("mismatch at %0t: VGA_VS expected %b, got %b",
                     $time, $sampled(exp_vs), $sampled(vga_vs));
            stop_run();
        end

    assert property (@(posedge clk) disable iff (reset) vga_blank_n == exp_blank_n)
        else begin
            $display("mismatch at %0t: VGA_BLANK_n expected %b, got %b",
                     $time, $sampled(exp_blank_n), $sampled(vga_blank_n));
            stop_run();
        end

    assert property (@(posedge clk) disable iff (reset) vga_clk == model_h[0])
        else begin
            $display("mismatch at %0t: VGA_CLK expected %b, got %b",
                     $time, $sampled(model_h[0]), $sampled(vga_clk));
            stop_run();
        end

    assert property (@(posedge clk) disable iff (reset) vga_sync_n == 1'b0)
        else begin
            $display("mismatch at %0t: VGA_SYNC_n expected 0, got %b", $time, $sampled(vga_sync_n));
            stop_run();
        end

    assert property (@(posedge clk) disable iff (reset)
        !exp_active |-> ({vga_r, vga_g, vga_b} == '0))
        else begin
            $display("mismatch at %0t: VGA_RGB in blanking expected 000000, got %h",
                     $time, $sampled({vga_r, vga_g, vga_b}));
            stop_run();
        end

    assert property (@(posedge clk) disable iff (reset) vga_r == exp_r)
        else begin
            $display("mismatch at %0t: VGA_R expected %0d, got %0d",
                     $time, $sampled(exp_r), $sampled(vga_r));
            stop_run();
        end

    assert property (@(posedge clk) disable iff (reset) vga_g == exp_g)
        else begin
            $display("mismatch at %0t: VGA_G expected %0d, got %0d",
                     $time, $sampled(exp_g), $sampled(vga_g));
            stop_run();
        end

    assert property (@(posedge clk) disable iff (reset) vga_b == exp_b)
        else begin
            $display("mismatch at %0t: VGA_B expected %0d, got %0d",
                     $time, $sampled(exp_b), $sampled(vga_b));
            stop_run();
        end

    // Returns on the edge that closes column 0 of the given line
    task automatic wait_for_line(input int line);
        int n;
        n = 0;
        @(posedge clk);
        while (!(model_v == line && model_h == 0) && n < WAIT_LIMIT) begin
            n++;
            @(posedge clk);
        end
        if (n >= WAIT_LIMIT) begin
            $display("timeout while waiting for raster line %0d", line);
            stop_run();
        end
    endtask

    task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
        chipselect <= 1'b1;
        write      <= 1'b1;
        address    <= addr;
        writedata  <= data;
        @(posedge clk);
        chipselect <= 1'b0;
        write      <= 1'b0;
        @(posedge clk);
    endtask

    initial begin
        seed       = 32'hc225;
        reset      = 1'b1;
        chipselect = 1'b0;
        write      = 1'b0;
        address    = '0;
        writedata  = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // Frame one by day, digit 0 at the reset position
        wait_for_line(VBLANK_LINE);
        digit = {$random(seed)} % 10;
        pos_x = {$random(seed)} % 200;
        pos_y = {$random(seed)} % 200;
        bus_write(REG_SCORE, DATA_W'(digit));
        bus_write(REG_SCORE_X, DATA_W'(pos_x));
        bus_write(REG_SCORE_Y, DATA_W'(pos_y));

        // Frame two, night starts partway down
        wait_for_line(VBLANK_LINE);
        bus_write(ADDR_W'(300), DATA_W'((digit + 5) % 10));

        // Frame three is all night with the same digit
        wait_for_line(VBLANK_LINE);
        bus_write(REG_SCORE, DATA_W'(12));

        wait_for_line(VBLANK_LINE);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
